/* verilog.f */
design/rop_pkg.sv
design/rop_req_arb.sv
design/rop_depth_test.sv
design/rop_blend.sv
design/rop_merge.sv
design/rop_top.sv
dv/rop_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the ROP testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
    -f verilog.f \
    --top-module rop_tb \
    -o rop_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/rop_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

grep -q "^Testbench passed$" "$LOG"
if [ $? -ne 0 ]; then
    echo "pass message not found in $LOG"
    exit 1
fi

exit 0

/* dv/rop_tb.sv */
module rop_tb;

    localparam int FRAGS_PER_PORT = 12;
    localparam int NUM_PHASES     = 8;
    localparam int PHASE_TIMEOUT  = 2000;

    logic                              clk = 1'b0;
    logic                              arst_n;

    logic                              req0_valid;
    logic                              req0_ready;
    logic [rop_pkg::UUID_BITS-1:0]     req0_uuid;
    logic                              req0_mask;
    logic [rop_pkg::DIM_BITS-1:0]      req0_pos_x;
    logic [rop_pkg::DIM_BITS-1:0]      req0_pos_y;
    logic [rop_pkg::COLOR_BITS-1:0]    req0_color;
    logic [rop_pkg::DEPTH_BITS-1:0]    req0_depth;
    logic [rop_pkg::COLOR_BITS-1:0]    req0_dst_color;
    logic [rop_pkg::DEPTH_BITS-1:0]    req0_dst_depth;

    logic                              req1_valid;
    logic                              req1_ready;
    logic [rop_pkg::UUID_BITS-1:0]     req1_uuid;
    logic                              req1_mask;
    logic [rop_pkg::DIM_BITS-1:0]      req1_pos_x;
    logic [rop_pkg::DIM_BITS-1:0]      req1_pos_y;
    logic [rop_pkg::COLOR_BITS-1:0]    req1_color;
    logic [rop_pkg::DEPTH_BITS-1:0]    req1_depth;
    logic [rop_pkg::COLOR_BITS-1:0]    req1_dst_color;
    logic [rop_pkg::DEPTH_BITS-1:0]    req1_dst_depth;

    rop_pkg::depth_func_t              depth_func;
    rop_pkg::blend_op_t                blend_op;
    logic                              depth_write_en;

    logic                              wr_valid;
    logic                              wr_ready;
    logic [rop_pkg::UUID_BITS-1:0]     wr_uuid;
    logic [rop_pkg::DIM_BITS-1:0]      wr_pos_x;
    logic [rop_pkg::DIM_BITS-1:0]      wr_pos_y;
    logic [rop_pkg::COLOR_BITS-1:0]    wr_color;
    logic [rop_pkg::DEPTH_BITS-1:0]    wr_depth;
    logic                              wr_color_we;
    logic                              wr_depth_we;

    // expected writes, indexed by uuid.
    bit                                sent [256];
    bit                                written [256];
    bit                                exp_port [256];
    logic [rop_pkg::COLOR_BITS-1:0]    exp_color [256];
    logic [rop_pkg::DEPTH_BITS-1:0]    exp_depth [256];
    logic [rop_pkg::DIM_BITS-1:0]      exp_pos_x [256];
    logic [rop_pkg::DIM_BITS-1:0]      exp_pos_y [256];
    bit                                exp_cwe [256];
    bit                                exp_dwe [256];

    // per-port issue order.
    logic [rop_pkg::UUID_BITS-1:0]     order0 [256];
    logic [rop_pkg::UUID_BITS-1:0]     order1 [256];
    logic [7:0]                        issued0 = 8'd0;
    logic [7:0]                        issued1 = 8'd0;
    logic [7:0]                        rd0 = 8'd0;
    logic [7:0]                        rd1 = 8'd0;

    logic [31:0]                       lcg_state;
    int                                sent_cnt = 0;
    int                                written_cnt = 0;
    bit                                timed_out = 1'b0;
    int                                wr_errors = 0;
    int                                arb_errors = 0;
    int                                hold_errors = 0;
    int                                run_errors = 0;

    logic                              last_grant;
    logic                              stalled;
    logic [85:0]                       held;
    logic [85:0]                       wr_fields;

    assign wr_fields = {wr_uuid, wr_pos_x, wr_pos_y, wr_color, wr_depth,
                        wr_color_we, wr_depth_we};

    rop_top i_rop_top (.*);

    always #5 clk = ~clk;

    // ======================================
    // reference model
    // ======================================

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic bit chance(input int pct);
        logic [31:0] r;
        r = next_rand();
        return (32'(r[31:16]) % 100) < pct;
    endfunction

    function automatic bit depth_passes(input rop_pkg::depth_func_t f,
                                        input logic [rop_pkg::DEPTH_BITS-1:0] s,
                                        input logic [rop_pkg::DEPTH_BITS-1:0] d);
        bit lt;
        bit eq;
        bit gt;
        lt = s < d;
        eq = s == d;
        gt = s > d;
        case (f)
            rop_pkg::LESS:     return lt;
            rop_pkg::EQUAL:    return eq;
            rop_pkg::LEQUAL:   return lt || eq;
            rop_pkg::GREATER:  return gt;
            rop_pkg::NOTEQUAL: return !eq;
            rop_pkg::GEQUAL:   return gt || eq;
            rop_pkg::ALWAYS:   return 1'b1;
            default:           return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] blend_color(input rop_pkg::blend_op_t op,
                                                input logic [31:0] s,
                                                input logic [31:0] d);
        logic [31:0] res;
        logic [8:0]  sum;
        logic [15:0] prod;
        logic [7:0]  a;
        logic [7:0]  b;
        for (int i = 0; i < 4; i++) begin
            a    = s[8*i +: 8];
            b    = d[8*i +: 8];
            sum  = {1'b0, a} + {1'b0, b};
            prod = {8'h0, a} * {8'h0, b};
            case (op)
                rop_pkg::ADD_SAT: res[8*i +: 8] = (sum > 9'd255) ? 8'hff : sum[7:0];
                rop_pkg::MUL:     res[8*i +: 8] = prod[15:8];
                rop_pkg::MAX:     res[8*i +: 8] = (a > b) ? a : b;
                default:          res[8*i +: 8] = a;
            endcase
        end
        return res;
    endfunction

    // ======================================
    // stimulus
    // ======================================

    task automatic make_fragment(input bit port);
        logic [7:0]  u;
        logic [31:0] c;
        logic [31:0] dc;
        logic [31:0] r;
        logic [31:0] r2;
        logic [23:0] d;
        logic [23:0] dd;
        u  = sent_cnt[7:0];
        c  = next_rand();
        dc = next_rand();
        r  = next_rand();
        r2 = next_rand();
        d  = 24'h400000 + {2'b00, r[21:0]};
        // dst above, below or equal to src.
        case (r[31:30])
            2'd1:    dd = d + {16'h0, r[29:22]} + 24'd1;
            2'd2:    dd = d - {16'h0, r[29:22]} - 24'd1;
            default: dd = d;
        endcase
        exp_port[u]  = port;
        exp_color[u] = blend_color(blend_op, c, dc);
        exp_depth[u] = d;
        exp_pos_x[u] = r2[9:0];
        exp_pos_y[u] = r2[19:10];
        exp_cwe[u]   = (r2[31:30] != 2'b00) && depth_passes(depth_func, d, dd);
        exp_dwe[u]   = exp_cwe[u] && depth_write_en;
        sent[u]      = 1'b1;
        sent_cnt++;
        if (port == 1'b0) begin
            req0_valid     = 1'b1;
            req0_uuid      = u;
            req0_mask      = (r2[31:30] != 2'b00);
            req0_pos_x     = r2[9:0];
            req0_pos_y     = r2[19:10];
            req0_color     = c;
            req0_depth     = d;
            req0_dst_color = dc;
            req0_dst_depth = dd;
        end else begin
            req1_valid     = 1'b1;
            req1_uuid      = u;
            req1_mask      = (r2[31:30] != 2'b00);
            req1_pos_x     = r2[9:0];
            req1_pos_y     = r2[19:10];
            req1_color     = c;
            req1_depth     = d;
            req1_dst_color = dc;
            req1_dst_depth = dd;
        end
    endtask

    // one configuration, run until every fragment is written.
    task automatic run_phase(input int phase);
        int left0;
        int left1;
        int cycles;
        int load_pct;
        int ready_pct;
        bit fired0;
        bit fired1;
        left0          = FRAGS_PER_PORT;
        left1          = FRAGS_PER_PORT;
        cycles         = 0;
        load_pct       = (phase % 2 == 0) ? 100 : 50;
        ready_pct      = (phase == 0) ? 100 : 70;
        depth_func     = rop_pkg::depth_func_t'(phase[2:0]);
        blend_op       = rop_pkg::blend_op_t'(phase[1:0]);
        depth_write_en = phase[0] ^ phase[2];
        while (!timed_out && (left0 > 0 || left1 > 0 || req0_valid || req1_valid ||
                              written_cnt != sent_cnt)) begin
            @(posedge clk);
            fired0 = req0_valid && req0_ready;
            fired1 = req1_valid && req1_ready;
            #1;
            wr_ready = chance(ready_pct);
            if (fired0) begin
                order0[issued0] = req0_uuid;
                issued0 = issued0 + 8'd1;
                req0_valid = 1'b0;
            end
            if (fired1) begin
                order1[issued1] = req1_uuid;
                issued1 = issued1 + 8'd1;
                req1_valid = 1'b0;
            end
            if (!req0_valid && left0 > 0 && chance(load_pct)) begin
                make_fragment(1'b0);
                left0--;
            end
            if (!req1_valid && left1 > 0 && chance(load_pct)) begin
                make_fragment(1'b1);
                left1--;
            end
            cycles++;
            if (cycles > PHASE_TIMEOUT) begin
                $display("timeout: phase %0d did not finish within %0d cycles",
                         phase, PHASE_TIMEOUT);
                run_errors++;
                timed_out = 1'b1;
            end
        end
    endtask

    // ======================================
    // checks
    // ======================================

    function automatic int field_mismatch(input string name, input logic [31:0] got,
                                          input logic [31:0] exp);
        int bad;
        bad = 0;
        assert (got == exp) else begin
            $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
            bad = 1;
        end
        return bad;
    endfunction

    task automatic check_write();
        logic [7:0] u;
        u = wr_uuid;
        assert (sent[u]) else begin
            $display("uuid 0x%0h was written but never sent", u);
            wr_errors++;
        end
        assert (!written[u]) else begin
            $display("uuid 0x%0h was written more than once", u);
            wr_errors++;
        end
        if (sent[u]) begin
            if (exp_port[u] == 1'b0) begin
                wr_errors += field_mismatch("wr_uuid", 32'(u), 32'(order0[rd0]));
                rd0 = rd0 + 8'd1;
            end else begin
                wr_errors += field_mismatch("wr_uuid", 32'(u), 32'(order1[rd1]));
                rd1 = rd1 + 8'd1;
            end
            wr_errors += field_mismatch("wr_color", wr_color, exp_color[u]);
            wr_errors += field_mismatch("wr_depth", 32'(wr_depth), 32'(exp_depth[u]));
            wr_errors += field_mismatch("wr_pos_x", 32'(wr_pos_x), 32'(exp_pos_x[u]));
            wr_errors += field_mismatch("wr_pos_y", 32'(wr_pos_y), 32'(exp_pos_y[u]));
            wr_errors += field_mismatch("wr_color_we", 32'(wr_color_we), 32'(exp_cwe[u]));
            wr_errors += field_mismatch("wr_depth_we", 32'(wr_depth_we), 32'(exp_dwe[u]));
            written[u] = 1'b1;
            written_cnt++;
        end
    endtask

    // write port: held data under stalls, then the scoreboard.
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stalled <= 1'b0;
            held    <= '0;
        end else begin
            if (stalled) begin
                assert (wr_fields == held) else begin
                    wr_errors++;
                    $display("CHECK FAILED wr_fields held 0x%0h now 0x%0h", held, wr_fields);
                end
            end
            stalled <= wr_valid && !wr_ready;
            held    <= wr_fields;
            if (wr_valid && wr_ready) begin
                check_write();
            end
        end
    end

    // round robin, port 0 first after reset.
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            last_grant <= 1'b1;
        end else begin
            assert (!(req0_ready && req1_ready)) else begin
                arb_errors++;
                $display("CHECK FAILED req0_ready 0x%0h req1_ready 0x%0h", req0_ready,
                         req1_ready);
            end
            if (req0_valid && req1_valid && (req0_ready || req1_ready)) begin
                assert (req1_ready == !last_grant) else begin
                    arb_errors++;
                    $display("CHECK FAILED req1_ready got 0x%0h expected 0x%0h", req1_ready,
                             !last_grant);
                end
            end
            if (req0_valid && req0_ready) begin
                last_grant <= 1'b0;
            end else if (req1_valid && req1_ready) begin
                last_grant <= 1'b1;
            end
        end
    end

    a_wr_valid_held: assert property (@(posedge clk) disable iff (!arst_n)
        wr_valid && !wr_ready |=> wr_valid)
        else begin
            hold_errors++;
            $display("CHECK FAILED wr_valid got 0x%0h expected 0x1", wr_valid);
        end

    initial begin
        lcg_state      = 32'd94936;
        arst_n         = 1'b0;
        {req0_valid, req0_uuid, req0_mask, req0_pos_x, req0_pos_y,
         req0_color, req0_depth, req0_dst_color, req0_dst_depth} = '0;
        {req1_valid, req1_uuid, req1_mask, req1_pos_x, req1_pos_y,
         req1_color, req1_depth, req1_dst_color, req1_dst_depth} = '0;
        depth_func     = rop_pkg::NEVER;
        blend_op       = rop_pkg::REPLACE;
        depth_write_en = 1'b0;
        wr_ready       = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;
        assert (!wr_valid) else begin
            run_errors++;
            $display("CHECK FAILED wr_valid got 0x%0h expected 0x0", wr_valid);
        end
        for (int p = 0; p < NUM_PHASES; p++) begin
            if (!timed_out) begin
                run_phase(p);
            end
        end
        for (int u = 0; u < sent_cnt; u++) begin
            assert (written[u[7:0]]) else begin
                run_errors++;
                $display("uuid 0x%0h was sent but never written", u);
            end
        end
        $display("errors: write %0d, arbiter %0d, hold %0d, run %0d",
                 wr_errors, arb_errors, hold_errors, run_errors);
        if (wr_errors + arb_errors + hold_errors + run_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* design/rop_top.sv */
module rop_top (
    input  logic                              clk,
    input  logic                              arst_n,

    input  logic                              req0_valid,
    output logic                              req0_ready,
    input  logic [rop_pkg::UUID_BITS-1:0]     req0_uuid,
    input  logic                              req0_mask,
    input  logic [rop_pkg::DIM_BITS-1:0]      req0_pos_x,
    input  logic [rop_pkg::DIM_BITS-1:0]      req0_pos_y,
    input  logic [rop_pkg::COLOR_BITS-1:0]    req0_color,
    input  logic [rop_pkg::DEPTH_BITS-1:0]    req0_depth,
    input  logic [rop_pkg::COLOR_BITS-1:0]    req0_dst_color,
    input  logic [rop_pkg::DEPTH_BITS-1:0]    req0_dst_depth,

    input  logic                              req1_valid,
    output logic                              req1_ready,
    input  logic [rop_pkg::UUID_BITS-1:0]     req1_uuid,
    input  logic                              req1_mask,
    input  logic [rop_pkg::DIM_BITS-1:0]      req1_pos_x,
    input  logic [rop_pkg::DIM_BITS-1:0]      req1_pos_y,
    input  logic [rop_pkg::COLOR_BITS-1:0]    req1_color,
    input  logic [rop_pkg::DEPTH_BITS-1:0]    req1_depth,
    input  logic [rop_pkg::COLOR_BITS-1:0]    req1_dst_color,
    input  logic [rop_pkg::DEPTH_BITS-1:0]    req1_dst_depth,

    // static, changed only while idle.
    input  rop_pkg::depth_func_t              depth_func,
    input  rop_pkg::blend_op_t                blend_op,
    input  logic                              depth_write_en,

    output logic                              wr_valid,
    input  logic                              wr_ready,
    output logic [rop_pkg::UUID_BITS-1:0]     wr_uuid,
    output logic [rop_pkg::DIM_BITS-1:0]      wr_pos_x,
    output logic [rop_pkg::DIM_BITS-1:0]      wr_pos_y,
    output logic [rop_pkg::COLOR_BITS-1:0]    wr_color,
    output logic [rop_pkg::DEPTH_BITS-1:0]    wr_depth,
    output logic                              wr_color_we,
    output logic                              wr_depth_we
);

    // arbiter fork, shared fragment fields.
    logic                              dt_valid;
    logic                              dt_ready;
    logic                              bl_valid;
    logic                              bl_ready;
    logic [rop_pkg::UUID_BITS-1:0]     uuid;
    logic                              mask;
    logic [rop_pkg::DIM_BITS-1:0]      pos_x;
    logic [rop_pkg::DIM_BITS-1:0]      pos_y;
    logic [rop_pkg::COLOR_BITS-1:0]    color;
    logic [rop_pkg::DEPTH_BITS-1:0]    depth;
    logic [rop_pkg::COLOR_BITS-1:0]    dst_color;
    logic [rop_pkg::DEPTH_BITS-1:0]    dst_depth;

    // unit results into the merge.
    logic                              dt_out_valid;
    logic                              dt_out_ready;
    logic                              dt_out_pass;
    logic                              dt_out_mask;
    logic [rop_pkg::DEPTH_BITS-1:0]    dt_out_depth;
    logic [rop_pkg::UUID_BITS-1:0]     dt_out_uuid;
    logic [rop_pkg::DIM_BITS-1:0]      dt_out_pos_x;
    logic [rop_pkg::DIM_BITS-1:0]      dt_out_pos_y;
    logic                              bl_out_valid;
    logic                              bl_out_ready;
    logic [rop_pkg::COLOR_BITS-1:0]    bl_out_color;

    rop_req_arb i_arb (.*);

    rop_depth_test i_depth (.*, .in_valid(dt_valid), .in_ready(dt_ready));

    rop_blend i_blend (
        .*,
        .in_valid  (bl_valid),
        .in_ready  (bl_ready),
        .out_valid (bl_out_valid),
        .out_color (bl_out_color),
        .out_ready (bl_out_ready)
    );

    rop_merge i_merge (.*);

endmodule

/* design/rop_merge.sv */
module rop_merge (
    input  logic                              clk,
    input  logic                              arst_n,

    input  logic                              dt_out_valid,
    output logic                              dt_out_ready,
    input  logic                              dt_out_pass,
    input  logic                              dt_out_mask,
    input  logic [rop_pkg::DEPTH_BITS-1:0]    dt_out_depth,
    input  logic [rop_pkg::UUID_BITS-1:0]     dt_out_uuid,
    input  logic [rop_pkg::DIM_BITS-1:0]      dt_out_pos_x,
    input  logic [rop_pkg::DIM_BITS-1:0]      dt_out_pos_y,

    input  logic                              bl_out_valid,
    output logic                              bl_out_ready,
    input  logic [rop_pkg::COLOR_BITS-1:0]    bl_out_color,

    input  logic                              depth_write_en,

    output logic                              wr_valid,
    input  logic                              wr_ready,
    output logic [rop_pkg::UUID_BITS-1:0]     wr_uuid,
    output logic [rop_pkg::DIM_BITS-1:0]      wr_pos_x,
    output logic [rop_pkg::DIM_BITS-1:0]      wr_pos_y,
    output logic [rop_pkg::COLOR_BITS-1:0]    wr_color,
    output logic [rop_pkg::DEPTH_BITS-1:0]    wr_depth,
    output logic                              wr_color_we,
    output logic                              wr_depth_we
);

    rop_pkg::merge_state_t state;
    logic                  join_fire;

    assign wr_valid = (state == rop_pkg::FULL);

    // both units are popped together, results pair up in stream order.
    assign join_fire    = dt_out_valid && bl_out_valid && (!wr_valid || wr_ready);
    assign dt_out_ready = join_fire;
    assign bl_out_ready = join_fire;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= rop_pkg::EMPTY;
        end else if (join_fire) begin
            state <= rop_pkg::FULL;
        end else if (wr_ready) begin
            state <= rop_pkg::EMPTY;
        end
    end

    always_ff @(posedge clk) begin
        if (join_fire) begin
            wr_uuid     <= dt_out_uuid;
            wr_pos_x    <= dt_out_pos_x;
            wr_pos_y    <= dt_out_pos_y;
            wr_color    <= bl_out_color;
            wr_depth    <= dt_out_depth;
            wr_color_we <= dt_out_mask && dt_out_pass;
            wr_depth_we <= dt_out_mask && dt_out_pass && depth_write_en;
        end
    end

    a_pop_both: assert property (@(posedge clk) disable iff (!arst_n)
        (dt_out_valid && dt_out_ready) == (bl_out_valid && bl_out_ready));

endmodule

/* design/rop_blend.sv */
module rop_blend (
    input  logic                              clk,
    input  logic                              arst_n,

    input  logic                              in_valid,
    output logic                              in_ready,
    input  logic [rop_pkg::COLOR_BITS-1:0]    color,
    input  logic [rop_pkg::COLOR_BITS-1:0]    dst_color,

    input  rop_pkg::blend_op_t                blend_op,

    output logic                              out_valid,
    output logic [rop_pkg::COLOR_BITS-1:0]    out_color,
    input  logic                              out_ready
);

    logic                                s1_valid;
    logic                                s2_ready;
    logic [3:0][rop_pkg::CHAN_BITS-1:0]  s1_src;
    logic [3:0][rop_pkg::CHAN_BITS:0]    s1_sum;
    logic [3:0][2*rop_pkg::CHAN_BITS-1:0] s1_prod;
    logic [3:0][rop_pkg::CHAN_BITS-1:0]  s1_max;
    logic [3:0][rop_pkg::CHAN_BITS-1:0]  blend_res;

    // each stage moves when the next one is empty or draining.
    assign s2_ready = !out_valid || out_ready;
    assign in_ready = !s1_valid || s2_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (in_ready) begin
                s1_valid <= in_valid;
            end
            if (s2_ready) begin
                out_valid <= s1_valid;
            end
        end
    end

    // ======================================
    // stage 1: per-channel intermediates
    // ======================================

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            for (int i = 0; i < 4; i++) begin
                s1_src[i]  <= color[i*rop_pkg::CHAN_BITS +: rop_pkg::CHAN_BITS];
                s1_sum[i]  <= {1'b0, color[i*rop_pkg::CHAN_BITS +: rop_pkg::CHAN_BITS]}
                            + {1'b0, dst_color[i*rop_pkg::CHAN_BITS +: rop_pkg::CHAN_BITS]};
                s1_prod[i] <= color[i*rop_pkg::CHAN_BITS +: rop_pkg::CHAN_BITS]
                            * dst_color[i*rop_pkg::CHAN_BITS +: rop_pkg::CHAN_BITS];
                s1_max[i]  <= (color[i*rop_pkg::CHAN_BITS +: rop_pkg::CHAN_BITS] >
                               dst_color[i*rop_pkg::CHAN_BITS +: rop_pkg::CHAN_BITS]) ?
                              color[i*rop_pkg::CHAN_BITS +: rop_pkg::CHAN_BITS] :
                              dst_color[i*rop_pkg::CHAN_BITS +: rop_pkg::CHAN_BITS];
            end
        end
    end

    // ======================================
    // stage 2: select and saturate
    // ======================================

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            case (blend_op)
                rop_pkg::REPLACE: blend_res[i] = s1_src[i];
                // carry out of the sum clamps to 255.
                rop_pkg::ADD_SAT: blend_res[i] = s1_sum[i][rop_pkg::CHAN_BITS] ?
                                                 '1 : s1_sum[i][rop_pkg::CHAN_BITS-1:0];
                rop_pkg::MUL:     blend_res[i] = s1_prod[i][2*rop_pkg::CHAN_BITS-1 -:
                                                            rop_pkg::CHAN_BITS];
                rop_pkg::MAX:     blend_res[i] = s1_max[i];
                default:          blend_res[i] = s1_src[i];
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid && s2_ready) begin
            out_color <= blend_res;
        end
    end

    a_s2_hold: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_color));

endmodule

/* design/rop_depth_test.sv */
module rop_depth_test (
    input  logic                              clk,
    input  logic                              arst_n,

    input  logic                              in_valid,
    output logic                              in_ready,
    input  logic [rop_pkg::UUID_BITS-1:0]     uuid,
    input  logic                              mask,
    input  logic [rop_pkg::DIM_BITS-1:0]      pos_x,
    input  logic [rop_pkg::DIM_BITS-1:0]      pos_y,
    input  logic [rop_pkg::DEPTH_BITS-1:0]    depth,
    input  logic [rop_pkg::DEPTH_BITS-1:0]    dst_depth,

    input  rop_pkg::depth_func_t              depth_func,

    output logic                              dt_out_valid,
    input  logic                              dt_out_ready,
    output logic                              dt_out_pass,
    output logic                              dt_out_mask,
    output logic [rop_pkg::DEPTH_BITS-1:0]    dt_out_depth,
    output logic [rop_pkg::UUID_BITS-1:0]     dt_out_uuid,
    output logic [rop_pkg::DIM_BITS-1:0]      dt_out_pos_x,
    output logic [rop_pkg::DIM_BITS-1:0]      dt_out_pos_y
);

    logic pass;
    logic load;

    // unsigned compare of src against dst.
    always_comb begin
        case (depth_func)
            rop_pkg::NEVER:    pass = 1'b0;
            rop_pkg::LESS:     pass = depth <  dst_depth;
            rop_pkg::EQUAL:    pass = depth == dst_depth;
            rop_pkg::LEQUAL:   pass = depth <= dst_depth;
            rop_pkg::GREATER:  pass = depth >  dst_depth;
            rop_pkg::NOTEQUAL: pass = depth != dst_depth;
            rop_pkg::GEQUAL:   pass = depth >= dst_depth;
            rop_pkg::ALWAYS:   pass = 1'b1;
            default:           pass = 1'b0;
        endcase
    end

    assign in_ready = !dt_out_valid || dt_out_ready;
    assign load     = in_valid && in_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dt_out_valid <= 1'b0;
        end else if (in_ready) begin
            dt_out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            dt_out_pass  <= pass;
            dt_out_mask  <= mask;
            dt_out_depth <= depth;
            dt_out_uuid  <= uuid;
            dt_out_pos_x <= pos_x;
            dt_out_pos_y <= pos_y;
        end
    end

    a_out_hold: assert property (@(posedge clk) disable iff (!arst_n)
        dt_out_valid && !dt_out_ready |=> dt_out_valid &&
            $stable({dt_out_pass, dt_out_mask, dt_out_depth, dt_out_uuid,
                     dt_out_pos_x, dt_out_pos_y}));

endmodule

/* design/rop_req_arb.sv */
module rop_req_arb (
    input  logic                              clk,
    input  logic                              arst_n,

    input  logic                              req0_valid,
    output logic                              req0_ready,
    input  logic [rop_pkg::UUID_BITS-1:0]     req0_uuid,
    input  logic                              req0_mask,
    input  logic [rop_pkg::DIM_BITS-1:0]      req0_pos_x,
    input  logic [rop_pkg::DIM_BITS-1:0]      req0_pos_y,
    input  logic [rop_pkg::COLOR_BITS-1:0]    req0_color,
    input  logic [rop_pkg::DEPTH_BITS-1:0]    req0_depth,
    input  logic [rop_pkg::COLOR_BITS-1:0]    req0_dst_color,
    input  logic [rop_pkg::DEPTH_BITS-1:0]    req0_dst_depth,

    input  logic                              req1_valid,
    output logic                              req1_ready,
    input  logic [rop_pkg::UUID_BITS-1:0]     req1_uuid,
    input  logic                              req1_mask,
    input  logic [rop_pkg::DIM_BITS-1:0]      req1_pos_x,
    input  logic [rop_pkg::DIM_BITS-1:0]      req1_pos_y,
    input  logic [rop_pkg::COLOR_BITS-1:0]    req1_color,
    input  logic [rop_pkg::DEPTH_BITS-1:0]    req1_depth,
    input  logic [rop_pkg::COLOR_BITS-1:0]    req1_dst_color,
    input  logic [rop_pkg::DEPTH_BITS-1:0]    req1_dst_depth,

    input  logic                              dt_ready,
    input  logic                              bl_ready,
    output logic                              dt_valid,
    output logic                              bl_valid,
    output logic [rop_pkg::UUID_BITS-1:0]     uuid,
    output logic                              mask,
    output logic [rop_pkg::DIM_BITS-1:0]      pos_x,
    output logic [rop_pkg::DIM_BITS-1:0]      pos_y,
    output logic [rop_pkg::COLOR_BITS-1:0]    color,
    output logic [rop_pkg::DEPTH_BITS-1:0]    depth,
    output logic [rop_pkg::COLOR_BITS-1:0]    dst_color,
    output logic [rop_pkg::DEPTH_BITS-1:0]    dst_depth
);

    logic out_full;
    logic take;
    logic accept;
    logic grant0;
    logic grant1;
    logic fire0;
    logic fire1;
    logic rr_ptr;

    // fork only fires when both units can take the fragment.
    assign take     = out_full && dt_ready && bl_ready;
    assign dt_valid = take;
    assign bl_valid = take;
    assign accept   = !out_full || take;

    // rr_ptr low favours port 0.
    assign grant0     = req0_valid && (!req1_valid || !rr_ptr);
    assign grant1     = req1_valid && (!req0_valid || rr_ptr);
    assign req0_ready = accept && grant0;
    assign req1_ready = accept && grant1;
    assign fire0      = req0_valid && req0_ready;
    assign fire1      = req1_valid && req1_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_full <= 1'b0;
            rr_ptr   <= 1'b0;
        end else begin
            if (fire0 || fire1) begin
                out_full <= 1'b1;
            end else if (take) begin
                out_full <= 1'b0;
            end
            if (fire0) begin
                rr_ptr <= 1'b1;
            end else if (fire1) begin
                rr_ptr <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire0) begin
            {uuid, mask, pos_x, pos_y} <= {req0_uuid, req0_mask, req0_pos_x, req0_pos_y};
            {color, depth, dst_color, dst_depth} <=
                {req0_color, req0_depth, req0_dst_color, req0_dst_depth};
        end else if (fire1) begin
            {uuid, mask, pos_x, pos_y} <= {req1_uuid, req1_mask, req1_pos_x, req1_pos_y};
            {color, depth, dst_color, dst_depth} <=
                {req1_color, req1_depth, req1_dst_color, req1_dst_depth};
        end
    end

    a_one_grant: assert property (@(posedge clk) disable iff (!arst_n)
        !(fire0 && fire1));

    a_hold_blocked: assert property (@(posedge clk) disable iff (!arst_n)
        out_full && !take |=> out_full &&
            $stable({uuid, mask, pos_x, pos_y, color, depth, dst_color, dst_depth}));

endmodule

/* design/rop_pkg.sv */
package rop_pkg;

    // ======================================
    // widths
    // ======================================

    // fragment tag.
    localparam int UUID_BITS  = 8;

    // screen position per axis.
    localparam int DIM_BITS   = 10;

    // unsigned depth value.
    localparam int DEPTH_BITS = 24;

    // packed rgba, channel 0 in the low byte.
    localparam int COLOR_BITS = 32;
    localparam int CHAN_BITS  = COLOR_BITS / 4;

    // ======================================
    // opcodes and states
    // ======================================

    // src depth is compared against dst depth.
    typedef enum logic [2:0] {
        NEVER    = 3'd0,
        LESS     = 3'd1,
        EQUAL    = 3'd2,
        LEQUAL   = 3'd3,
        GREATER  = 3'd4,
        NOTEQUAL = 3'd5,
        GEQUAL   = 3'd6,
        ALWAYS   = 3'd7
    } depth_func_t;

    typedef enum logic [1:0] {
        REPLACE = 2'd0,
        ADD_SAT = 2'd1,
        MUL     = 2'd2,
        MAX     = 2'd3
    } blend_op_t;

    // merge output slot.
    typedef enum logic {
        EMPTY = 1'b0,
        FULL  = 1'b1
    } merge_state_t;

endpackage
